//--- source/spi_mode_pkg.sv
package spi_mode_pkg;

    //////////////////////////////
    // Bus limits and timing
    //////////////////////////////

    localparam int NUM_SLAVES      = 16;
    localparam int MAX_BITS        = 64;
    localparam int SS_GUARD_CYCLES = 4;  // i_clk cycles around the SCLK burst

    //////////////////////////////
    // Field types
    //////////////////////////////

    typedef logic [$clog2(MAX_BITS)-1:0]        bit_cnt_t;    // Transfer length minus one
    typedef logic [1:0]                         clk_div_t;    // Half period is 2**(value+1)
    typedef logic [4:0]                         half_cnt_t;   // Counts down one half period
    typedef logic [$clog2(2*MAX_BITS)-1:0]      edge_cnt_t;   // Up to 2N SCLK edges
    typedef logic [$clog2(NUM_SLAVES)-1:0]      slave_idx_t;
    typedef logic [NUM_SLAVES-1:0]              ss_vec_t;     // Active low, one bit per slave
    typedef logic [$clog2(SS_GUARD_CYCLES)-1:0] guard_cnt_t;

    // Per-transfer bus settings
    typedef struct packed {
        logic     cpol;       // SCLK level at rest
        logic     cpha;       // 1 moves sampling to the trailing edge
        logic     msb_first;
        clk_div_t clk_div;
        bit_cnt_t bit_cnt;
    } spi_mode_t;

endpackage

//--- source/spi_xfer_pkg.sv
package spi_xfer_pkg;

    import spi_mode_pkg::*;

    //////////////////////////////
    // Payload
    //////////////////////////////

    typedef logic [MAX_BITS-1:0] spi_word_t;  // Right-aligned transfer data

    //////////////////////////////
    // Handshake structs
    //////////////////////////////

    // One request describes a whole transfer
    typedef struct packed {
        spi_mode_t  mode;
        slave_idx_t slave;
        spi_word_t  tx_data;
    } spi_req_t;

    // Received word, zeros above the last bit
    typedef struct packed {
        spi_word_t rx_data;
    } spi_rsp_t;

endpackage

//--- source/spi_sclk_gen.sv
`timescale 1ns/1ns

module spi_sclk_gen import spi_mode_pkg::*; (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  logic      i_run,      // One-cycle start from the sequencer
    input  spi_mode_t i_mode,
    output logic      o_sclk,
    output logic      o_lead,     // High in the cycle SCLK leaves rest level
    output logic      o_trail,    // High in the cycle SCLK returns to rest level
    output logic      o_done
);

    half_cnt_t half_cnt;
    half_cnt_t half_reload;
    edge_cnt_t edge_cnt;
    edge_cnt_t last_edge;
    logic      phase;             // 0 at rest, 1 between lead and trail
    logic      active;

    // 2, 4, 8 or 16 cycles per half period, minus one for the count down
    assign half_reload = (half_cnt_t'(2) << i_mode.clk_div) - half_cnt_t'(1);

    // Edge 2N-1 is the last trailing edge
    assign last_edge = {i_mode.bit_cnt, 1'b1};

    //////////////////////////////
    // Edge timing
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            half_cnt <= '0;
            edge_cnt <= '0;
            phase    <= 1'b0;
            active   <= 1'b0;
            o_lead   <= 1'b0;
            o_trail  <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_lead  <= 1'b0;
            o_trail <= 1'b0;
            o_done  <= o_trail && !active;  // Only the final trail sees active low
            if (i_run) begin
                active   <= 1'b1;
                half_cnt <= half_reload;
                edge_cnt <= '0;
                phase    <= 1'b0;
            end else if (active) begin
                if (half_cnt == '0) begin
                    half_cnt <= half_reload;
                    phase    <= ~phase;
                    o_lead   <= ~phase;
                    o_trail  <= phase;
                    edge_cnt <= edge_cnt + 1'b1;
                    if (edge_cnt == last_edge) begin
                        active <= 1'b0;
                    end
                end else begin
                    half_cnt <= half_cnt - 1'b1;
                end
            end
        end
    end

    // Polarity applied last so the rest level follows the latched cpol
    assign o_sclk = phase ^ i_mode.cpol;

endmodule

//--- source/spi_shift_engine.sv
`timescale 1ns/1ns

module spi_shift_engine import spi_mode_pkg::*, spi_xfer_pkg::*; (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  logic      i_load,     // Start of a transfer
    input  spi_mode_t i_mode,
    input  spi_word_t i_tx_data,
    input  logic      i_lead,
    input  logic      i_trail,
    input  logic      i_miso,
    output logic      o_mosi,
    output spi_word_t o_rx_data
);

    spi_word_t tx_q;
    spi_word_t rx_q;
    bit_cnt_t  idx;               // Bits already presented on MOSI, minus one
    bit_cnt_t  next_idx;
    bit_cnt_t  rx_pos;
    bit_cnt_t  tx_pos;
    logic      first_q;           // No leading edge seen yet
    logic      sample;
    logic      shift;

    //////////////////////////////
    // Edge roles
    //////////////////////////////

    // With cpha 1 the first leading edge only presents bit 0, which load already did
    assign sample = i_mode.cpha ? i_trail : i_lead;
    assign shift  = i_mode.cpha ? (i_lead && !first_q) : i_trail;

    //////////////////////////////
    // Bit ordering
    //////////////////////////////

    assign next_idx = idx + 1'b1;
    assign rx_pos   = i_mode.msb_first ? i_mode.bit_cnt - idx : idx;
    assign tx_pos   = i_mode.msb_first ? i_mode.bit_cnt - next_idx : next_idx;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            idx     <= '0;
            first_q <= 1'b0;
            o_mosi  <= 1'b0;
        end else if (i_load) begin
            idx     <= '0;
            first_q <= 1'b1;
            o_mosi  <= i_tx_data[i_mode.msb_first ? i_mode.bit_cnt : bit_cnt_t'(0)];
        end else begin
            if (i_lead) begin
                first_q <= 1'b0;
            end
            if (shift) begin
                idx    <= next_idx;
                o_mosi <= tx_q[tx_pos];  // Wraps past the last bit, never sampled
            end
        end
    end

    // Shift data
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            tx_q <= i_tx_data;
            rx_q <= '0;                  // Keeps bits above N-1 at zero
        end else if (sample) begin
            rx_q[rx_pos] <= i_miso;
        end
    end

    assign o_rx_data = rx_q;

endmodule

//--- source/spi_xfer_ctrl.sv
`timescale 1ns/1ns

module spi_xfer_ctrl import spi_mode_pkg::*, spi_xfer_pkg::*; (
    input  logic      i_clk,
    input  logic      i_arst_n,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    input  spi_req_t  i_req,
    output logic      o_rsp_valid,
    input  logic      i_rsp_ready,
    output spi_rsp_t  o_rsp,
    output spi_mode_t o_mode,     // Latched settings for the datapath
    output spi_word_t o_tx_data,
    output logic      o_run,
    output logic      o_load,
    input  logic      i_done,
    input  spi_word_t i_rx_data,
    output ss_vec_t   o_ss_n
);

    typedef enum logic [2:0] {
        IDLE,
        LEAD_GUARD,
        SHIFT,
        TRAIL_GUARD,
        RESPOND
    } state_t;

    state_t     state;
    guard_cnt_t guard_cnt;
    logic       guard_end;
    logic       req_fire;
    logic       rsp_valid_q;
    slave_idx_t slave_q;
    spi_word_t  tx_q;
    spi_rsp_t   rsp_q;

    assign req_fire  = i_req_valid && o_req_ready;
    assign guard_end = guard_cnt == guard_cnt_t'(SS_GUARD_CYCLES - 1);

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= IDLE;
            guard_cnt   <= '0;
            rsp_valid_q <= 1'b0;
            o_mode      <= '0;              // SCLK rests low until the first request
        end else begin
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        state     <= LEAD_GUARD;
                        guard_cnt <= '0;
                        o_mode    <= i_req.mode;
                    end
                end
                LEAD_GUARD: begin
                    if (guard_end) state <= SHIFT;
                    else           guard_cnt <= guard_cnt + 1'b1;
                end
                SHIFT: begin
                    if (i_done) begin
                        state     <= TRAIL_GUARD;
                        guard_cnt <= '0;
                    end
                end
                TRAIL_GUARD: begin
                    if (guard_end) state <= RESPOND;   // Slave select released here
                    else           guard_cnt <= guard_cnt + 1'b1;
                end
                RESPOND: begin
                    if (!rsp_valid_q) begin
                        rsp_valid_q <= 1'b1;
                    end else if (i_rsp_ready) begin
                        rsp_valid_q <= 1'b0;
                        state       <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            slave_q <= i_req.slave;
            tx_q    <= i_req.tx_data;
        end
        if (state == TRAIL_GUARD && guard_end) begin
            rsp_q.rx_data <= i_rx_data;
        end
    end

    assign o_req_ready = state == IDLE;
    assign o_load      = state == LEAD_GUARD && guard_cnt == '0;
    assign o_run       = state == LEAD_GUARD && guard_end;
    assign o_ss_n      = (state inside {LEAD_GUARD, SHIFT, TRAIL_GUARD}) ?
                         ~(ss_vec_t'(1) << slave_q) : '1;
    assign o_tx_data   = tx_q;
    assign o_rsp       = rsp_q;
    assign o_rsp_valid = rsp_valid_q;

endmodule

//--- source/spi_master_top.sv
`timescale 1ns/1ns

module spi_master_top import spi_mode_pkg::*, spi_xfer_pkg::*; (
    input  logic     i_clk,
    input  logic     i_arst_n,
    // Request
    input  logic     i_req_valid,
    output logic     o_req_ready,
    input  spi_req_t i_req,
    // Response
    output logic     o_rsp_valid,
    input  logic     i_rsp_ready,
    output spi_rsp_t o_rsp,
    // SPI bus
    output logic     o_sclk,
    output logic     o_mosi,
    input  logic     i_miso,
    output ss_vec_t  o_ss_n
);

    spi_mode_t mode;
    spi_word_t tx_data;
    spi_word_t rx_data;
    logic      run;
    logic      load;
    logic      lead;
    logic      trail;
    logic      done;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    spi_xfer_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req       (i_req),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp),
        .o_mode      (mode),
        .o_tx_data   (tx_data),
        .o_run       (run),
        .o_load      (load),
        .i_done      (done),
        .i_rx_data   (rx_data),
        .o_ss_n      (o_ss_n)
    );

    //////////////////////////////
    // Clock and datapath
    //////////////////////////////

    spi_sclk_gen u_sclk (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_run    (run),
        .i_mode   (mode),
        .o_sclk   (o_sclk),
        .o_lead   (lead),
        .o_trail  (trail),
        .o_done   (done)
    );

    spi_shift_engine u_shift (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_load    (load),
        .i_mode    (mode),
        .i_tx_data (tx_data),
        .i_lead    (lead),
        .i_trail   (trail),
        .i_miso    (i_miso),
        .o_mosi    (o_mosi),
        .o_rx_data (rx_data)
    );

endmodule

//--- verification/spi_master_properties.sv
`timescale 1ns/1ns

module spi_master_properties import spi_mode_pkg::*, spi_xfer_pkg::*; (
    input logic     i_clk,
    input logic     i_arst_n,
    input logic     o_req_ready,
    input logic     o_rsp_valid,
    input logic     i_rsp_ready,
    input spi_rsp_t o_rsp,
    input ss_vec_t  o_ss_n
);

    int assert_fails = 0;             // Read by the testbench at the end of the run

    //////////////////////////////
    // Bus and handshake rules
    //////////////////////////////

    ss_one_hot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_ss_n == '1) || $onehot(~o_ss_n))
        else begin
            assert_fails++;
            $error("o_ss_n selects more than one slave: %h", o_ss_n);
        end

    rsp_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)))
        else begin
            assert_fails++;
            $error("o_rsp changed or was dropped while stalled");
        end

    busy_not_ready: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_ss_n != '1) |-> !o_req_ready)
        else begin
            assert_fails++;
            $error("o_req_ready high while a slave is selected");
        end

endmodule

bind spi_master_top spi_master_properties u_props (.*);

//--- verification/spi_master_tb.sv
`timescale 1ns/1ns

module spi_master_tb import spi_mode_pkg::*, spi_xfer_pkg::*;;

    localparam int NUM_REQS       = 40;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = NUM_REQS * (2 * MAX_BITS * 16 + 2 * SS_GUARD_CYCLES + 40)
                                    + RESET_CYCLES;

    logic      i_clk;
    logic      i_arst_n;
    logic      i_req_valid;
    logic      o_req_ready;
    spi_req_t  i_req;
    logic      o_rsp_valid;
    logic      i_rsp_ready;
    spi_rsp_t  o_rsp;
    logic      o_sclk;
    logic      o_mosi;
    logic      i_miso;
    ss_vec_t   o_ss_n;

    logic [31:0] lfsr_state = 32'h6329_c3ee;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycle_cnt  = 0;
    spi_word_t   exp_q[$];        // Expected rx words in request order

    // Current transfer as seen by the slave model
    spi_mode_t   xfer_mode;
    slave_idx_t  xfer_slave;
    spi_word_t   xfer_tx;
    spi_word_t   xfer_pattern;
    logic        xfer_armed = 1'b0;
    logic        last_cpol  = 1'b0;
    logic        prev_ss_low;
    logic        prev_sclk;
    logic        ss_low;
    int          n_lead;
    int          n_trail;
    int          nbits;
    spi_word_t   mosi_cap;

    spi_master_top u_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic spi_word_t draw(int nbits_req);
        spi_word_t v;
        logic      fb;
        int        b;
        v = '0;
        for (b = 0; b < nbits_req; b++) begin
            fb          = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state  = {lfsr_state[30:0], fb};
            v           = {v[MAX_BITS-2:0], fb};
        end
        return v;
    endfunction

    function automatic int bit_pos(logic msb_first, int len, int k);
        return msb_first ? len - 1 - k : k;  // Wire order to word position
    endfunction

    function automatic spi_word_t low_mask(int len);
        spi_word_t ones;
        ones = '1;
        return ones >> (MAX_BITS - len);
    endfunction

    // All slaves idle except the addressed one
    function automatic ss_vec_t one_slave_low(slave_idx_t slave);
        ss_vec_t v;
        v        = '1;
        v[slave] = 1'b0;
        return v;
    endfunction

    task automatic check_word(string name, spi_word_t exp, spi_word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_ss(string name, ss_vec_t exp, ss_vec_t act);
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errs, other_errs, u_dut.u_props.assert_fails);
        if (value_errs + other_errs + u_dut.u_props.assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // One falling edge, with random back-pressure on the response side
    task automatic tick();
        spi_word_t rdy;
        @(negedge i_clk);
        rdy         = draw(2);
        i_rsp_ready = (rdy != '0);
        if (o_rsp_valid && i_rsp_ready) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("A response was handed over with no request outstanding");
            end else begin
                check_word("o_rsp.rx_data", exp_q.pop_front(), o_rsp.rx_data);
            end
        end
    endtask

    //////////////////////////////
    // SPI slave model
    //////////////////////////////

    task automatic start_xfer();
        if (!xfer_armed) begin
            other_errs++;
            $display("Slave select went low without an accepted request");
        end
        xfer_armed = 1'b0;
        last_cpol  = xfer_mode.cpol;
        nbits      = int'(xfer_mode.bit_cnt) + 1;
        n_lead     = 0;
        n_trail    = 0;
        mosi_cap   = '0;
        i_miso     = xfer_pattern[bit_pos(xfer_mode.msb_first, nbits, 0)];
    endtask

    task automatic sclk_edge(logic is_lead);
        if (is_lead) begin
            if (n_lead < nbits) begin
                if (!xfer_mode.cpha) begin
                    mosi_cap[bit_pos(xfer_mode.msb_first, nbits, n_lead)] = o_mosi;
                end else begin
                    i_miso = xfer_pattern[bit_pos(xfer_mode.msb_first, nbits, n_lead)];
                end
            end
            n_lead++;
        end else begin
            if (xfer_mode.cpha && n_trail < nbits) begin
                mosi_cap[bit_pos(xfer_mode.msb_first, nbits, n_trail)] = o_mosi;
            end
            n_trail++;
            if (!xfer_mode.cpha && n_trail < nbits) begin
                i_miso = xfer_pattern[bit_pos(xfer_mode.msb_first, nbits, n_trail)];
            end
        end
    endtask

    task automatic end_xfer();
        if (n_lead != nbits) begin
            value_errs++;
            $display("[ERROR] %0t o_sclk leading edges: expected %0d, got %0d",
                     $time, nbits, n_lead);
        end
        check_word("slave MOSI data", xfer_tx & low_mask(nbits), mosi_cap);
    endtask

    // Edges are at least two cycles apart, so one look per falling edge is enough
    always @(negedge i_clk) begin
        if (!i_arst_n) begin
            prev_ss_low = 1'b0;
            prev_sclk   = 1'b0;
        end else begin
            ss_low = (o_ss_n !== '1);
            if (!ss_low) check_bit("o_sclk", last_cpol, o_sclk);
            else         check_ss("o_ss_n", one_slave_low(xfer_slave), o_ss_n);
            if (ss_low && !prev_ss_low) begin
                start_xfer();
            end else if (ss_low && o_sclk !== prev_sclk) begin
                sclk_edge(o_sclk !== last_cpol);
            end else if (!ss_low && prev_ss_low) begin
                end_xfer();
            end
            prev_ss_low = ss_low;
            prev_sclk   = o_sclk;
        end
    end

    //////////////////////////////
    // Timeout
    //////////////////////////////

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            other_errs++;
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            finish_run();
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin : stimulus
        spi_req_t  req;
        spi_word_t pattern;
        int        gap;
        int        len;
        i_arst_n    = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_rsp_ready = 1'b0;
        i_miso      = 1'b0;
        repeat (RESET_CYCLES) tick();
        i_arst_n = 1'b1;
        tick();
        check_bit("o_req_ready", 1'b1, o_req_ready);
        check_bit("o_rsp_valid", 1'b0, o_rsp_valid);
        check_ss("o_ss_n", '1, o_ss_n);
        check_bit("o_sclk", 1'b0, o_sclk);
        check_bit("o_mosi", 1'b0, o_mosi);

        for (int i = 0; i < NUM_REQS; i++) begin
            req.mode.cpol      = (draw(1) != '0);
            req.mode.cpha      = (draw(1) != '0);
            req.mode.msb_first = (draw(1) != '0);
            req.mode.clk_div   = clk_div_t'(draw(2));
            req.mode.bit_cnt   = bit_cnt_t'(draw(6));
            req.slave          = slave_idx_t'(draw(4));
            req.tx_data        = draw(64);
            pattern            = draw(64);
            gap                = int'(draw(2));
            len                = int'(req.mode.bit_cnt) + 1;
            repeat (gap) tick();
            i_req       = req;
            i_req_valid = 1'b1;              // Held until the DUT is ready
            while (!o_req_ready) tick();
            if (exp_q.size() != 0) begin
                other_errs++;
                $display("A request was accepted before the previous response was taken");
            end
            xfer_mode    = req.mode;
            xfer_slave   = req.slave;
            xfer_tx      = req.tx_data;
            xfer_pattern = pattern;
            xfer_armed   = 1'b1;
            exp_q.push_back(pattern & low_mask(len));
            tick();                          // Accepted on the rising edge just passed
            i_req_valid = 1'b0;
        end

        while (exp_q.size() != 0) tick();
        repeat (8) tick();                   // Catch any extra response
        finish_run();
    end

endmodule

//--- src.f
source/spi_mode_pkg.sv
source/spi_xfer_pkg.sv
source/spi_sclk_gen.sv
source/spi_shift_engine.sv
source/spi_xfer_ctrl.sv
source/spi_master_top.sv
verification/spi_master_properties.sv
verification/spi_master_tb.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - source/spi_mode_pkg.sv
  - source/spi_xfer_pkg.sv
  - source/spi_sclk_gen.sv
  - source/spi_shift_engine.sv
  - source/spi_xfer_ctrl.sv
  - source/spi_master_top.sv
  - target: simulation
    files:
      - verification/spi_master_properties.sv
      - verification/spi_master_tb.sv
